// ==== up_cpu.f ====
src/up_pkg.sv
src/up_datapath.sv
src/up_control.sv
src/up_memory.sv
src/up_cpu.sv
verif/up_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module up_cpu_tb -f up_cpu.f -o up_cpu_sim \
   && ./obj_dir/up_cpu_sim | tee sim.log \
   || { echo "Build or simulation error"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation passed" \
   || { echo "No result in sim.log"; exit 1; }

// ==== verif/up_cpu_tests.txt ====
# Tokens: test <name>, reset, load or check, then @addr and hex bytes at rising addresses, run
# Code byte k sits at 0x00+k and its shadow operand at 0x80+k
test alu
reset
load @04 60 71 70 EF 72 70 EF 73 70 EF 74 70 EF 75 70 EF 8F
load @84 30 25 55 10 60 F5 16 03 DF 1C F0 2F 22 3C 13 28 00
run
check @94 13
test nibble
reset
load @04 7B 8F 70 8F @84 5A 00 77 00
run
check @85 5A @87 00
test jumps
reset
load @04 70 D0 8F 60 E0 8F 80 60 E0 70 8F 8F
load @84 C3 0E 00 C3 14 00 00 01 1E 3E 00 00
run
check @86 00 @89 00 C3 @8E 3E 00
test stack
reset
load @04 7B 09 7B 09 7B 0A 99 F0 @84 11 00 22 00 00 @FC 00 00 00 00
run
check @FC 00 22 22 11
test restart
load @0B F7 08 F0 @8C 6B 00
run
check @8D 6B

// ==== verif/up_cpu_tb.sv ====
module up_cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam string TEST_FILE = "verif/up_cpu_tests.txt";
   localparam int CYCLES_PER_BYTE = 40;
   localparam int K_TEST = 0;
   localparam int K_RESET = 1;
   localparam int K_LOAD = 2;
   localparam int K_CHECK = 3;
   localparam int K_RUN = 4;

   logic       clk;
   logic       nRst;
   logic       start;
   logic       halted;
   logic       ld_we;
   logic [7:0] ld_addr;
   logic [7:0] ld_data;
   logic [7:0] ld_q;

   int         kind_q[$];
   string      name_q[$];
   logic [7:0] addr_q[$];
   logic [7:0] data_q[$];

   int    cycles = 0;
   int    limit = 0;
   int    errors = 0;
   int    checks = 0;
   string cur_test = "none";

   up_cpu #(
      .PC_INIT (8'd8),
      .SP_INIT (8'd255)
   ) i_up_cpu (
      .clk     (clk),
      .nRst    (nRst),
      .start   (start),
      .halted  (halted),
      .ld_we   (ld_we),
      .ld_addr (ld_addr),
      .ld_data (ld_data),
      .ld_q    (ld_q)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   function automatic void add_step(int kind, string name, logic [7:0] a, logic [7:0] d);
      kind_q.push_back(kind);
      name_q.push_back(name);
      addr_q.push_back(a);
      data_q.push_back(d);
   endfunction

   task automatic read_tests();
      int         fd;
      int         n;
      int         mode;
      int         nbytes;
      string      tok;
      string      line;
      logic [7:0] addr;
      logic [7:0] val;
      nbytes = 0;
      mode = K_LOAD;
      addr = 8'h00;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the test file %s", TEST_FILE);
         errors++;
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok[0] == "#") begin
            n = $fgets(line, fd);  // Rest of a comment line
         end else if (tok == "test") begin
            n = $fscanf(fd, "%s", tok);
            add_step(K_TEST, tok, 8'h00, 8'h00);
         end else if (tok == "reset") begin
            add_step(K_RESET, "", 8'h00, 8'h00);
         end else if (tok == "load") begin
            mode = K_LOAD;
         end else if (tok == "check") begin
            mode = K_CHECK;
         end else if (tok == "run") begin
            add_step(K_RUN, "", 8'h00, 8'h00);
         end else if (tok[0] == "@") begin
            n = $sscanf(tok.substr(1, tok.len() - 1), "%h", addr);
         end else begin
            n = $sscanf(tok, "%h", val);
            add_step(mode, "", addr, val);
            addr++;
            if (mode == K_LOAD) begin
               nbytes++;
            end
         end
      end
      $fclose(fd);
      limit = CYCLES_PER_BYTE * nbytes;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      nRst <= 1'b0;
      repeat (5) @(posedge clk);
      nRst <= 1'b1;
   endtask

   task automatic load_byte(logic [7:0] a, logic [7:0] d);
      @(posedge clk);
      ld_we   <= 1'b1;
      ld_addr <= a;
      ld_data <= d;
   endtask

   task automatic run_program();
      @(posedge clk);
      ld_we <= 1'b0;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;  // Sequencer has left IDLE or HALT here
      @(negedge clk);
      checks++;
      assert (!halted) else begin
         $display("Test %s: halted stayed high after the start pulse", cur_test);
         errors++;
      end
      while (!halted) begin
         @(negedge clk);
      end
   endtask

   task automatic check_byte(logic [7:0] a, logic [7:0] expected);
      @(posedge clk);
      ld_we   <= 1'b0;
      ld_addr <= a;
      @(negedge clk);
      checks++;
      assert (ld_q === expected) else begin
         $display("Fail %s: byte %h expected %h actual %h", cur_test, a, expected, ld_q);
         errors++;
      end
   endtask

   // Watchdog
   initial begin
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
      end
      $display("Timeout: test %s did not halt within %0d cycles", cur_test, limit);
      $display("Checks: %0d, errors: %0d, timeouts: 1", checks, errors);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      nRst    = 1'b0;
      start   = 1'b0;
      ld_we   = 1'b0;
      ld_addr = 8'h00;
      ld_data = 8'h00;
      read_tests();
      foreach (kind_q[i]) begin
         case (kind_q[i])
            K_TEST:  cur_test = name_q[i];
            K_RESET: apply_reset();
            K_LOAD:  load_byte(addr_q[i], data_q[i]);
            K_RUN:   run_program();
            default: check_byte(addr_q[i], data_q[i]);
         endcase
      end
      $display("Checks: %0d, errors: %0d, timeouts: 0", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== src/up_cpu.sv ====
module up_cpu import up_pkg::*; #(
   parameter byte_t PC_INIT = 8'd8,
   parameter byte_t SP_INIT = 8'd255
) (
   input  logic  clk,
   input  logic  nRst,
   input  logic  start,
   output logic  halted,
   input  logic  ld_we,
   input  byte_t ld_addr,
   input  byte_t ld_data,
   output byte_t ld_q
);

   byte_t   data_in;
   byte_t   data_out;
   dp_op_t  op;
   rb_sel_t rb_sel_in;
   nibble_t ir;
   logic    z;
   logic    ir_we;
   logic    pc_we;
   logic    rb_we;
   logic    sp_we;
   logic    mar_we;
   logic    mem_we;

   up_datapath #(
      .PC_INIT (PC_INIT),
      .SP_INIT (SP_INIT)
   ) i_up_datapath (
      .clk       (clk),
      .nRst      (nRst),
      .data_in   (data_in),
      .op        (op),
      .ir_we     (ir_we),
      .pc_we     (pc_we),
      .rb_sel_in (rb_sel_in),
      .rb_we     (rb_we),
      .sp_we     (sp_we),
      .data_out  (data_out),
      .ir        (ir),
      .z         (z)
   );

   up_control i_up_control (
      .clk       (clk),
      .nRst      (nRst),
      .start     (start),
      .ir        (ir),
      .z         (z),
      .op        (op),
      .ir_we     (ir_we),
      .pc_we     (pc_we),
      .rb_sel_in (rb_sel_in),
      .rb_we     (rb_we),
      .sp_we     (sp_we),
      .mar_we    (mar_we),
      .mem_we    (mem_we),
      .halted    (halted)
   );

   up_memory i_up_memory (
      .clk     (clk),
      .nRst    (nRst),
      .mar_we  (mar_we),
      .mem_we  (mem_we),
      .wdata   (data_out),
      .rdata   (data_in),
      .ld_we   (ld_we),
      .ld_addr (ld_addr),
      .ld_data (ld_data),
      .ld_q    (ld_q)
   );

endmodule

// ==== src/up_memory.sv ====
module up_memory import up_pkg::*; (
   input  logic  clk,
   input  logic  nRst,
   input  logic  mar_we,
   input  logic  mem_we,
   input  byte_t wdata,
   output byte_t rdata,
   input  logic  ld_we,
   input  byte_t ld_addr,
   input  byte_t ld_data,
   output byte_t ld_q
);

   byte_t mem [256];
   byte_t mar;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         mar <= 8'h00;
      end else if (mar_we) begin
         mar <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mar] <= wdata;
      end else if (ld_we) begin
         mem[ld_addr] <= ld_data;  // Loader only while CPU is stopped
      end
   end

   assign rdata = mem[mar];
   assign ld_q  = mem[ld_addr];

endmodule

// ==== src/up_control.sv ====
module up_control import up_pkg::*; (
   input  logic    clk,
   input  logic    nRst,
   input  logic    start,
   input  nibble_t ir,
   input  logic    z,
   output dp_op_t  op,
   output logic    ir_we,
   output logic    pc_we,
   output rb_sel_t rb_sel_in,
   output logic    rb_we,
   output logic    sp_we,
   output logic    mar_we,
   output logic    mem_we,
   output logic    halted
);

   seq_state_t state;
   seq_state_t state_nxt;
   isa_t       instr;

   assign instr  = isa_t'(ir);
   assign halted = (state == HALT);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, HALT: begin
            if (start) begin
               state_nxt = FETCH_A;  // Restart resumes at the pc after HLT
            end
         end
         FETCH_A: state_nxt = FETCH_D;
         FETCH_D: state_nxt = EXEC1;
         EXEC1: begin
            case (instr)
               HLT:                                 state_nxt = HALT;
               LDA, LDB, STA, JMP, JZ, PUSH, POP:   state_nxt = EXEC2;
               default:                             state_nxt = FETCH_A;
            endcase
         end
         EXEC2: begin
            if (instr == PUSH || instr == POP) begin
               state_nxt = EXEC3;
            end else begin
               state_nxt = FETCH_A;
            end
         end
         default: state_nxt = FETCH_A;
      endcase
   end

   always_comb begin
      op        = OP_K0;
      ir_we     = 1'b0;
      pc_we     = 1'b0;
      rb_sel_in = SEL_I0;
      rb_we     = 1'b0;
      sp_we     = 1'b0;
      mar_we    = 1'b0;
      mem_we    = 1'b0;
      case (state)
         FETCH_A: begin
            op     = OP_CADDR;
            mar_we = 1'b1;
         end
         FETCH_D: begin
            op    = OP_PCINC;  // ir picks its nibble by the old pc[0]
            pc_we = 1'b1;
            ir_we = 1'b1;
         end
         EXEC1: begin
            case (instr)
               ADD, SUB, MUL, NAND, XOR: begin
                  case (instr)
                     ADD:     op = OP_ADD;
                     SUB:     op = OP_SUB;
                     MUL:     op = OP_MUL;
                     NAND:    op = OP_NAND;
                     default: op = OP_X12;
                  endcase
                  rb_sel_in = SEL_O1;
                  rb_we     = 1'b1;
               end
               MOV: begin
                  op        = OP_R2;
                  rb_sel_in = SEL_O3;
                  rb_we     = 1'b1;
               end
               CLR: begin
                  op        = OP_K0;
                  rb_sel_in = SEL_O0;
                  rb_we     = 1'b1;
               end
               LDA, LDB, STA, JMP, JZ: begin
                  op     = OP_DADDR;  // Shadow of the already advanced pc
                  mar_we = 1'b1;
               end
               PUSH: begin
                  op     = OP_SP;
                  mar_we = 1'b1;
               end
               POP: begin
                  op    = OP_SPINC;
                  sp_we = 1'b1;
               end
               default: ;
            endcase
         end
         EXEC2: begin
            case (instr)
               LDA: begin
                  op        = OP_MEM;
                  rb_sel_in = SEL_I1;
                  rb_we     = 1'b1;
               end
               LDB: begin
                  op        = OP_MEM;
                  rb_sel_in = SEL_I2;
                  rb_we     = 1'b1;
               end
               STA: begin
                  op     = OP_R2;
                  mem_we = 1'b1;
               end
               JMP: begin
                  op    = OP_MEM;
                  pc_we = 1'b1;
               end
               JZ: begin
                  op    = OP_MEM;
                  pc_we = z;  // Not taken writes nothing
               end
               PUSH: begin
                  op     = OP_R3;
                  mem_we = 1'b1;
               end
               POP: begin
                  op     = OP_SP;
                  mar_we = 1'b1;
               end
               default: ;
            endcase
         end
         EXEC3: begin
            if (instr == PUSH) begin
               op    = OP_SPDEC;
               sp_we = 1'b1;
            end else begin
               op        = OP_MEM;
               rb_sel_in = SEL_I3;
               rb_we     = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

// ==== src/up_datapath.sv ====
module up_datapath import up_pkg::*; #(
   parameter byte_t PC_INIT = 8'd8,
   parameter byte_t SP_INIT = 8'd255
) (
   input  logic    clk,
   input  logic    nRst,
   input  byte_t   data_in,
   input  dp_op_t  op,
   input  logic    ir_we,
   input  logic    pc_we,
   input  rb_sel_t rb_sel_in,
   input  logic    rb_we,
   input  logic    sp_we,
   output byte_t   data_out,
   output nibble_t ir,
   output logic    z
);

   byte_t pc;
   byte_t sp;
   byte_t r0;
   byte_t r1;
   byte_t r2;
   byte_t r3;
   byte_t rb_d;

   assign z = (r1 == r2);

   always_comb begin
      case (op)
         OP_ADD:   data_out = r1 + r2;
         OP_SUB:   data_out = r1 - r2;
         OP_MUL:   data_out = r1 * r2;    // Low 8 bits only
         OP_NAND:  data_out = ~(r1 & r2);
         OP_X01:   data_out = r0 ^ r1;
         OP_X12:   data_out = r1 ^ r2;
         OP_X23:   data_out = r2 ^ r3;
         OP_K0:    data_out = 8'h00;
         OP_K1:    data_out = 8'h01;
         OP_K2:    data_out = 8'h02;
         OP_K3:    data_out = 8'h03;
         OP_CADDR: data_out = {1'b0, pc[7:1]};
         OP_DADDR: data_out = {1'b1, pc[7:1]};
         OP_PCINC: data_out = pc + 8'd1;
         OP_PCDEC: data_out = pc - 8'd1;
         OP_PC:    data_out = pc;
         OP_R2:    data_out = r2;
         OP_R3:    data_out = r3;
         OP_SPINC: data_out = sp + 8'd1;
         OP_SP:    data_out = sp;
         OP_SPDEC: data_out = sp - 8'd1;
         default:  data_out = data_in;
      endcase
   end

   // Register file takes memory or the result bus
   assign rb_d = rb_sel_in[2] ? data_out : data_in;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_INIT;
         sp <= SP_INIT;
         ir <= 4'h0;
         r0 <= 8'h00;
         r1 <= 8'h00;
         r2 <= 8'h00;
         r3 <= 8'h00;
      end else begin
         if (pc_we) begin
            pc <= data_out;
         end
         if (sp_we) begin
            sp <= data_out;
         end
         if (ir_we) begin
            ir <= pc[0] ? data_in[3:0] : data_in[7:4];  // High nibble first
         end
         if (rb_we) begin
            case (rb_sel_in[1:0])
               2'd0:    r0 <= rb_d;
               2'd1:    r1 <= rb_d;
               2'd2:    r2 <= rb_d;
               default: r3 <= rb_d;
            endcase
         end
      end
   end

endmodule

// ==== src/up_pkg.sv ====
package up_pkg;

   typedef logic [7:0] byte_t;    // Data, address and register value
   typedef logic [3:0] nibble_t;  // One instruction
   typedef logic [4:0] dp_op_t;   // Result bus select
   typedef logic [2:0] rb_sel_t;  // Register write select

   localparam dp_op_t OP_ADD   = 5'b00000;
   localparam dp_op_t OP_SUB   = 5'b00001;
   localparam dp_op_t OP_MUL   = 5'b00010;
   localparam dp_op_t OP_NAND  = 5'b00011;
   localparam dp_op_t OP_X01   = 5'b00100;
   localparam dp_op_t OP_X12   = 5'b00101;
   localparam dp_op_t OP_X23   = 5'b00110;
   localparam dp_op_t OP_K0    = 5'b10000;
   localparam dp_op_t OP_K1    = 5'b10001;
   localparam dp_op_t OP_K2    = 5'b10010;
   localparam dp_op_t OP_K3    = 5'b10011;
   localparam dp_op_t OP_CADDR = 5'b10100;  // Code byte of pc
   localparam dp_op_t OP_PCINC = 5'b10101;
   localparam dp_op_t OP_R3    = 5'b10110;
   localparam dp_op_t OP_SPINC = 5'b10111;
   localparam dp_op_t OP_SP    = 5'b11001;
   localparam dp_op_t OP_SPDEC = 5'b11010;
   localparam dp_op_t OP_PC    = 5'b11011;
   localparam dp_op_t OP_R2    = 5'b11100;
   localparam dp_op_t OP_PCDEC = 5'b11101;
   localparam dp_op_t OP_DADDR = 5'b11110;  // Shadow byte of pc
   localparam dp_op_t OP_MEM   = 5'b11111;  // Pass data_in

   // Top bit picks data_out, low bits pick r0 to r3
   localparam rb_sel_t SEL_I0 = 3'b000;
   localparam rb_sel_t SEL_I1 = 3'b001;
   localparam rb_sel_t SEL_I2 = 3'b010;
   localparam rb_sel_t SEL_I3 = 3'b011;
   localparam rb_sel_t SEL_O0 = 3'b100;
   localparam rb_sel_t SEL_O1 = 3'b101;
   localparam rb_sel_t SEL_O2 = 3'b110;
   localparam rb_sel_t SEL_O3 = 3'b111;

   typedef enum logic [3:0] {
      NOP  = 4'h0,
      ADD  = 4'h1,
      SUB  = 4'h2,
      MUL  = 4'h3,
      NAND = 4'h4,
      XOR  = 4'h5,
      LDA  = 4'h6,
      LDB  = 4'h7,
      STA  = 4'h8,
      PUSH = 4'h9,
      POP  = 4'hA,
      MOV  = 4'hB,
      CLR  = 4'hC,
      JMP  = 4'hD,
      JZ   = 4'hE,
      HLT  = 4'hF
   } isa_t;

   typedef enum logic [2:0] {
      IDLE,
      FETCH_A,
      FETCH_D,
      EXEC1,
      EXEC2,
      EXEC3,
      HALT
   } seq_state_t;

endpackage
